// ==== logic/gpu_pkg.sv ====
package gpu_pkg;

        //////////////////////////////////////////////////
        // widths
        //////////////////////////////////////////////////
        localparam int WORD_W     = 32;
        localparam int ADDR_W     = 32;
        localparam int REG_IDX_W  = 3;

        // default depth of the copy FIFO, in words
        localparam int FIFO_DEPTH = 8;

        typedef logic [WORD_W-1:0]    word_t;
        typedef logic [ADDR_W-1:0]    addr_t;
        typedef logic [WORD_W-1:0]    len_t;
        typedef logic [REG_IDX_W-1:0] reg_idx_t;

        //////////////////////////////////////////////////
        // register map
        //////////////////////////////////////////////////
        localparam reg_idx_t REG_SRC    = 3'd0;
        localparam reg_idx_t REG_DST    = 3'd1;
        localparam reg_idx_t REG_LEN    = 3'd2;
        localparam reg_idx_t REG_CTRL   = 3'd3;
        localparam reg_idx_t REG_STATUS = 3'd4;

        localparam int CTRL_GO_BIT   = 0;
        localparam int STAT_BUSY_BIT = 0;
        localparam int STAT_DONE_BIT = 1;

        typedef enum logic [1:0] {
                MC_IDLE,
                MC_RUN,
                MC_FINISH
        } memcpy_state_e;

        //////////////////////////////////////////////////
        // port bundles
        //////////////////////////////////////////////////
        typedef struct packed {
                logic     req;
                logic     we;
                reg_idx_t idx;
                word_t    wdata;
        } host_req_t;

        typedef struct packed {
                logic  ack;
                word_t rdata;
        } host_rsp_t;

        typedef struct packed {
                addr_t src;
                addr_t dst;
                len_t  len;
        } copy_cfg_t;

        typedef struct packed {
                logic  req;
                addr_t addr;
        } mem_rd_req_t;

        typedef struct packed {
                logic  ack;
                word_t data;
        } mem_rd_rsp_t;

        typedef struct packed {
                logic  req;
                addr_t addr;
                word_t data;
        } mem_wr_req_t;

endpackage

// ==== logic/gpu_regs.sv ====
`timescale 1ns/10ps

module gpu_regs (
        input  logic                i_wire_clock,
        input  logic                i_arst_n,
        input  gpu_pkg::host_req_t  i_host,
        output gpu_pkg::host_rsp_t  o_host,
        output gpu_pkg::copy_cfg_t  o_cfg,
        output logic                o_start,
        input  logic                i_busy,
        input  logic                i_done
);

        gpu_pkg::host_rsp_t rsp_q;
        gpu_pkg::copy_cfg_t cfg_q;
        logic               start_q;
        logic               done_q;
        logic               access;
        logic               wr_access;
        logic               go_accept;
        gpu_pkg::word_t     status;
        gpu_pkg::word_t     rd_word;

        // a new access is a req not yet answered
        assign access    = i_host.req && !rsp_q.ack;
        assign wr_access = access && i_host.we;

        // go only counts while the sequencer is idle
        assign go_accept = wr_access && (i_host.idx == gpu_pkg::REG_CTRL) &&
                           i_host.wdata[gpu_pkg::CTRL_GO_BIT] && !i_busy;

        always_comb begin
                status = '0;
                status[gpu_pkg::STAT_BUSY_BIT] = i_busy;
                status[gpu_pkg::STAT_DONE_BIT] = done_q;
        end

        // read mux, ctrl and unmapped indices give zero
        always_comb begin
                case (i_host.idx)
                        gpu_pkg::REG_SRC:    rd_word = cfg_q.src;
                        gpu_pkg::REG_DST:    rd_word = cfg_q.dst;
                        gpu_pkg::REG_LEN:    rd_word = cfg_q.len;
                        gpu_pkg::REG_STATUS: rd_word = status;
                        default:             rd_word = '0;
                endcase
        end

        //////////////////////////////////////////////////
        // host handshake and register writes
        //////////////////////////////////////////////////
        always_ff @(posedge i_wire_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        rsp_q   <= '0;
                        cfg_q   <= '0;
                        start_q <= 1'b0;
                        done_q  <= 1'b0;
                end else begin
                        // ack follows req by one edge in both directions
                        rsp_q.ack <= i_host.req;
                        if (access && !i_host.we) begin
                                rsp_q.rdata <= rd_word;
                        end
                        if (wr_access) begin
                                case (i_host.idx)
                                        gpu_pkg::REG_SRC: cfg_q.src <= i_host.wdata;
                                        gpu_pkg::REG_DST: cfg_q.dst <= i_host.wdata;
                                        gpu_pkg::REG_LEN: cfg_q.len <= i_host.wdata;
                                        default: ;
                                endcase
                        end
                        start_q <= go_accept;
                        // sticky done, cleared by the next accepted go
                        if (go_accept) begin
                                done_q <= 1'b0;
                        end else if (i_done) begin
                                done_q <= 1'b1;
                        end
                end
        end

        assign o_host  = rsp_q;
        assign o_cfg   = cfg_q;
        assign o_start = start_q;

endmodule

// ==== logic/gpu_memcpy.sv ====
`timescale 1ns/10ps

module gpu_memcpy (
        input  logic                i_wire_clock,
        input  logic                i_arst_n,
        input  gpu_pkg::copy_cfg_t  i_cfg,
        input  logic                i_start,
        output logic                o_busy,
        output logic                o_done,
        output gpu_pkg::addr_t      o_rd_addr,
        output gpu_pkg::addr_t      o_wr_addr,
        output gpu_pkg::len_t       o_len,
        output logic                o_launch,
        output logic                o_flush,
        input  logic                i_rd_finished,
        input  logic                i_wr_finished
);

        gpu_pkg::memcpy_state_e state_q;
        gpu_pkg::copy_cfg_t     cfg_q;
        logic                   launch_q;
        logic                   rd_seen_q;
        logic                   wr_seen_q;
        logic                   rd_all;
        logic                   wr_all;
        logic                   take;

        assign take   = (state_q == gpu_pkg::MC_IDLE) && i_start;

        // a finished pulse counts on the cycle it arrives
        assign rd_all = rd_seen_q || i_rd_finished;
        assign wr_all = wr_seen_q || i_wr_finished;

        //////////////////////////////////////////////////
        // sequencer
        //////////////////////////////////////////////////
        always_ff @(posedge i_wire_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        state_q   <= gpu_pkg::MC_IDLE;
                        launch_q  <= 1'b0;
                        rd_seen_q <= 1'b0;
                        wr_seen_q <= 1'b0;
                end else begin
                        launch_q <= take;
                        case (state_q)
                                gpu_pkg::MC_IDLE: begin
                                        if (i_start) begin
                                                state_q   <= gpu_pkg::MC_RUN;
                                                rd_seen_q <= 1'b0;
                                                wr_seen_q <= 1'b0;
                                        end
                                end
                                gpu_pkg::MC_RUN: begin
                                        rd_seen_q <= rd_all;
                                        wr_seen_q <= wr_all;
                                        if (rd_all && wr_all) begin
                                                state_q <= gpu_pkg::MC_FINISH;
                                        end
                                end
                                default: state_q <= gpu_pkg::MC_IDLE;
                        endcase
                end
        end

        // copy settings held for the whole run
        always_ff @(posedge i_wire_clock) begin
                if (take) begin
                        cfg_q <= i_cfg;
                end
        end

        assign o_busy    = (state_q != gpu_pkg::MC_IDLE);
        assign o_done    = (state_q == gpu_pkg::MC_FINISH);
        assign o_launch  = launch_q;
        // empty the FIFO on the same edge the engines load
        assign o_flush   = launch_q;
        assign o_rd_addr = cfg_q.src;
        assign o_wr_addr = cfg_q.dst;
        assign o_len     = cfg_q.len;

endmodule

// ==== logic/gpu_dma_reader.sv ====
`timescale 1ns/10ps

module gpu_dma_reader (
        input  logic                  i_wire_clock,
        input  logic                  i_arst_n,
        input  gpu_pkg::addr_t        i_addr,
        input  gpu_pkg::len_t         i_len,
        input  logic                  i_launch,
        output logic                  o_finished,
        output gpu_pkg::mem_rd_req_t  o_mem_rd,
        input  gpu_pkg::mem_rd_rsp_t  i_mem_rd,
        input  logic                  i_fifo_full,
        output logic                  o_fifo_push,
        output gpu_pkg::word_t        o_fifo_data
);

        gpu_pkg::addr_t addr_q;
        gpu_pkg::len_t  remain_q;
        logic           active_q;
        logic           req_q;
        logic           idle_slot;

        // between words, no req out and the previous ack gone
        assign idle_slot  = active_q && !req_q && !i_mem_rd.ack;
        assign o_finished = idle_slot && (remain_q == '0);

        // returned word goes into the FIFO while ack is high
        assign o_fifo_push = req_q && i_mem_rd.ack;
        assign o_fifo_data = i_mem_rd.data;

        assign o_mem_rd = '{req: req_q, addr: addr_q};

        always_ff @(posedge i_wire_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        active_q <= 1'b0;
                        req_q    <= 1'b0;
                        addr_q   <= '0;
                        remain_q <= '0;
                end else if (i_launch) begin
                        active_q <= 1'b1;
                        addr_q   <= i_addr;
                        remain_q <= i_len;
                end else if (o_fifo_push) begin
                        req_q    <= 1'b0;
                        addr_q   <= addr_q + gpu_pkg::ADDR_W'(4);
                        remain_q <= remain_q - 1'b1;
                end else if (o_finished) begin
                        active_q <= 1'b0;
                end else if (idle_slot && !i_fifo_full) begin
                        // room for one more word, the only one in flight
                        req_q <= 1'b1;
                end
        end

endmodule

// ==== logic/gpu_fifo.sv ====
`timescale 1ns/10ps

module gpu_fifo #(
        parameter int DEPTH = gpu_pkg::FIFO_DEPTH
) (
        input  logic            i_wire_clock,
        input  logic            i_arst_n,
        input  logic            i_flush,
        input  logic            i_push,
        input  gpu_pkg::word_t  i_data,
        output logic            o_full,
        input  logic            i_pop,
        output gpu_pkg::word_t  o_data,
        output logic            o_empty
);

        localparam int PTR_W = $clog2(DEPTH);

        gpu_pkg::word_t   mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr_q;
        logic [PTR_W-1:0] rd_ptr_q;
        logic [PTR_W:0]   count_q;
        logic             wr_en;
        logic             rd_en;

        assign o_full  = (count_q == DEPTH);
        assign o_empty = (count_q == '0);
        assign wr_en   = i_push && !o_full;
        assign rd_en   = i_pop && !o_empty;

        // head word always visible
        assign o_data  = mem[rd_ptr_q];

        always_ff @(posedge i_wire_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                end else if (i_flush) begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                end else begin
                        // pointers wrap on their own for power of two depths
                        if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
                        if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
                        count_q <= count_q + wr_en - rd_en;
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (wr_en) begin
                        mem[wr_ptr_q] <= i_data;
                end
        end

endmodule

// ==== logic/gpu_dma_writer.sv ====
`timescale 1ns/10ps

module gpu_dma_writer (
        input  logic                  i_wire_clock,
        input  logic                  i_arst_n,
        input  gpu_pkg::addr_t        i_addr,
        input  gpu_pkg::len_t         i_len,
        input  logic                  i_launch,
        output logic                  o_finished,
        input  logic                  i_fifo_empty,
        input  gpu_pkg::word_t        i_fifo_data,
        output logic                  o_fifo_pop,
        output gpu_pkg::mem_wr_req_t  o_mem_wr,
        input  logic                  i_mem_wr_ack
);

        gpu_pkg::addr_t addr_q;
        gpu_pkg::len_t  remain_q;
        gpu_pkg::word_t data_q;
        logic           active_q;
        logic           req_q;
        logic           idle_slot;
        logic           accepted;

        assign idle_slot  = active_q && !req_q && !i_mem_wr_ack;
        assign o_finished = idle_slot && (remain_q == '0);
        assign o_fifo_pop = idle_slot && (remain_q != '0) && !i_fifo_empty;
        assign accepted   = req_q && i_mem_wr_ack;

        assign o_mem_wr = '{req: req_q, addr: addr_q, data: data_q};

        always_ff @(posedge i_wire_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        active_q <= 1'b0;
                        req_q    <= 1'b0;
                        addr_q   <= '0;
                        remain_q <= '0;
                end else if (i_launch) begin
                        active_q <= 1'b1;
                        addr_q   <= i_addr;
                        remain_q <= i_len;
                end else if (accepted) begin
                        // step only once the word has landed
                        req_q    <= 1'b0;
                        addr_q   <= addr_q + gpu_pkg::ADDR_W'(4);
                        remain_q <= remain_q - 1'b1;
                end else if (o_finished) begin
                        active_q <= 1'b0;
                end else if (o_fifo_pop) begin
                        req_q <= 1'b1;
                end
        end

        // popped word held on the port until ack
        always_ff @(posedge i_wire_clock) begin
                if (o_fifo_pop) begin
                        data_q <= i_fifo_data;
                end
        end

endmodule

// ==== logic/gpu_top.sv ====
`timescale 1ns/10ps

module gpu_top (
        input  logic                  i_wire_clock,
        input  logic                  i_arst_n,
        input  gpu_pkg::host_req_t    i_host,
        output gpu_pkg::host_rsp_t    o_host,
        output gpu_pkg::mem_rd_req_t  o_mem_rd,
        input  gpu_pkg::mem_rd_rsp_t  i_mem_rd,
        output gpu_pkg::mem_wr_req_t  o_mem_wr,
        input  logic                  i_mem_wr_ack
);

        gpu_pkg::copy_cfg_t cfg;
        logic               start;
        logic               busy;
        logic               done;
        gpu_pkg::addr_t     rd_addr;
        gpu_pkg::addr_t     wr_addr;
        gpu_pkg::len_t      len;
        logic               launch;
        logic               flush;
        logic               rd_finished;
        logic               wr_finished;
        logic               fifo_push;
        logic               fifo_full;
        logic               fifo_pop;
        logic               fifo_empty;
        gpu_pkg::word_t     fifo_wdata;
        gpu_pkg::word_t     fifo_rdata;

        //////////////////////////////////////////////////
        // control
        //////////////////////////////////////////////////
        gpu_regs u_regs (
                .i_wire_clock (i_wire_clock),
                .i_arst_n     (i_arst_n),
                .i_host       (i_host),
                .o_host       (o_host),
                .o_cfg        (cfg),
                .o_start      (start),
                .i_busy       (busy),
                .i_done       (done)
        );

        gpu_memcpy u_memcpy (
                .i_wire_clock  (i_wire_clock),
                .i_arst_n      (i_arst_n),
                .i_cfg         (cfg),
                .i_start       (start),
                .o_busy        (busy),
                .o_done        (done),
                .o_rd_addr     (rd_addr),
                .o_wr_addr     (wr_addr),
                .o_len         (len),
                .o_launch      (launch),
                .o_flush       (flush),
                .i_rd_finished (rd_finished),
                .i_wr_finished (wr_finished)
        );

        //////////////////////////////////////////////////
        // data path, reader to FIFO to writer
        //////////////////////////////////////////////////
        gpu_dma_reader u_reader (
                .i_wire_clock (i_wire_clock),
                .i_arst_n     (i_arst_n),
                .i_addr       (rd_addr),
                .i_len        (len),
                .i_launch     (launch),
                .o_finished   (rd_finished),
                .o_mem_rd     (o_mem_rd),
                .i_mem_rd     (i_mem_rd),
                .i_fifo_full  (fifo_full),
                .o_fifo_push  (fifo_push),
                .o_fifo_data  (fifo_wdata)
        );

        gpu_fifo u_fifo (
                .i_wire_clock (i_wire_clock),
                .i_arst_n     (i_arst_n),
                .i_flush      (flush),
                .i_push       (fifo_push),
                .i_data       (fifo_wdata),
                .o_full       (fifo_full),
                .i_pop        (fifo_pop),
                .o_data       (fifo_rdata),
                .o_empty      (fifo_empty)
        );

        gpu_dma_writer u_writer (
                .i_wire_clock (i_wire_clock),
                .i_arst_n     (i_arst_n),
                .i_addr       (wr_addr),
                .i_len        (len),
                .i_launch     (launch),
                .o_finished   (wr_finished),
                .i_fifo_empty (fifo_empty),
                .i_fifo_data  (fifo_rdata),
                .o_fifo_pop   (fifo_pop),
                .o_mem_wr     (o_mem_wr),
                .i_mem_wr_ack (i_mem_wr_ack)
        );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
        parameter int PERIOD       = 20,
        parameter int RESET_CYCLES = 3
) (
        output logic o_clk,
        output logic o_arst_n
);

        initial begin
                o_clk = 1'b0;
                forever #(PERIOD / 2) o_clk = ~o_clk;
        end

        // reset released on a rising edge
        initial begin
                o_arst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge o_clk);
                o_arst_n <= 1'b1;
        end

endmodule

// ==== test/tb_gpu_assert.sv ====
`timescale 1ns/10ps

module tb_gpu_assert (
        input logic                  i_clk,
        input logic                  i_arst_n,
        input gpu_pkg::host_req_t    i_host,
        input gpu_pkg::host_rsp_t    i_host_rsp,
        input gpu_pkg::mem_rd_req_t  i_rd_req,
        input gpu_pkg::mem_rd_rsp_t  i_rd_rsp,
        input gpu_pkg::mem_wr_req_t  i_wr_req,
        input logic                  i_wr_ack
);

        // number of handshake rule violations so far
        int fail_count = 0;

        //////////////////////////////////////////////////
        // req held until ack, payload stable meanwhile
        //////////////////////////////////////////////////
        host_req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_host.req && !i_host_rsp.ack |=> i_host.req)
                else begin
                        $error("host req dropped before its ack");
                        fail_count++;
                end

        rd_req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_rd_req.req && !i_rd_rsp.ack |=> i_rd_req.req && $stable(i_rd_req.addr))
                else begin
                        $error("memory read req dropped or address moved before ack");
                        fail_count++;
                end

        wr_req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_wr_req.req && !i_wr_ack |=>
                i_wr_req.req && $stable(i_wr_req.addr) && $stable(i_wr_req.data))
                else begin
                        $error("memory write req dropped or payload moved before ack");
                        fail_count++;
                end

        //////////////////////////////////////////////////
        // no ack without a req
        //////////////////////////////////////////////////
        host_ack_has_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                $rose(i_host_rsp.ack) |-> i_host.req)
                else begin
                        $error("host ack rose with no req");
                        fail_count++;
                end

        rd_ack_has_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                $rose(i_rd_rsp.ack) |-> i_rd_req.req)
                else begin
                        $error("memory read ack rose with no req");
                        fail_count++;
                end

        wr_ack_has_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                $rose(i_wr_ack) |-> i_wr_req.req)
                else begin
                        $error("memory write ack rose with no req");
                        fail_count++;
                end

endmodule

bind gpu_top tb_gpu_assert u_handshake_checks (
        .i_clk      (i_wire_clock),
        .i_arst_n   (i_arst_n),
        .i_host     (i_host),
        .i_host_rsp (o_host),
        .i_rd_req   (o_mem_rd),
        .i_rd_rsp   (i_mem_rd),
        .i_wr_req   (o_mem_wr),
        .i_wr_ack   (i_mem_wr_ack)
);

// ==== test/tb_gpu.sv ====
`timescale 1ns/10ps

module tb_gpu;

        localparam int CLK_PERIOD   = 20;
        localparam int BUSY_LEN     = 16;
        // words moved by all copies together
        localparam int COPY_WORDS   = 20 + 40 + 0 + BUSY_LEN;
        localparam int LIMIT_CYCLES = COPY_WORDS * 12 + 2000;

        logic                  clk;
        logic                  arst_n;
        gpu_pkg::host_req_t    host_req;
        gpu_pkg::host_rsp_t    host_rsp;
        gpu_pkg::mem_rd_req_t  mem_rd_req;
        gpu_pkg::mem_rd_rsp_t  mem_rd_rsp;
        gpu_pkg::mem_wr_req_t  mem_wr_req;
        logic                  mem_wr_ack;

        gpu_pkg::word_t        mem_words [256];
        gpu_pkg::word_t        exp_mem [256];
        integer                seed = 32'hdcbadd11;
        logic                  slow_writes = 1'b0;
        int                    rd_count = 0;
        int                    wr_count = 0;
        int                    done_pulses = 0;

        tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (
                .o_clk    (clk),
                .o_arst_n (arst_n)
        );

        gpu_top dut (
                .i_wire_clock (clk),
                .i_arst_n     (arst_n),
                .i_host       (host_req),
                .o_host       (host_rsp),
                .o_mem_rd     (mem_rd_req),
                .i_mem_rd     (mem_rd_rsp),
                .o_mem_wr     (mem_wr_req),
                .i_mem_wr_ack (mem_wr_ack)
        );

        //////////////////////////////////////////////////
        // failure reporting and checks
        //////////////////////////////////////////////////
        task automatic stop_with_failure(input string why);
                $display("%s", why);
                $display("TESTS FAILED");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        stop_with_failure($sformatf("error at %0t ns: %s = %h, expected %h",
                                                    $time, name, got, exp));
                end
        endtask

        function automatic int pick_delay(input int lo, input int span);
                pick_delay = lo + ($unsigned($random(seed)) % span);
        endfunction

        always @(dut.u_handshake_checks.fail_count) begin
                if (dut.u_handshake_checks.fail_count != 0) begin
                        stop_with_failure("a four-phase handshake rule was broken");
                end
        end

        //////////////////////////////////////////////////
        // host port driver
        //////////////////////////////////////////////////
        task automatic host_write(input gpu_pkg::reg_idx_t idx, input gpu_pkg::word_t data);
                @(posedge clk);
                host_req <= '{req: 1'b1, we: 1'b1, idx: idx, wdata: data};
                do @(posedge clk); while (!host_rsp.ack);
                host_req.req <= 1'b0;
                do @(posedge clk); while (host_rsp.ack);
        endtask

        task automatic host_read(input gpu_pkg::reg_idx_t idx, output gpu_pkg::word_t data);
                @(posedge clk);
                host_req <= '{req: 1'b1, we: 1'b0, idx: idx, wdata: '0};
                do @(posedge clk); while (!host_rsp.ack);
                data = host_rsp.rdata;
                host_req.req <= 1'b0;
                do @(posedge clk); while (host_rsp.ack);
        endtask

        //////////////////////////////////////////////////
        // memory model, one process per port
        //////////////////////////////////////////////////
        initial begin
                int d;
                forever begin
                        @(posedge clk);
                        if (mem_rd_req.req === 1'b1 && !mem_rd_rsp.ack) begin
                                d = pick_delay(0, 4);
                                repeat (d) @(posedge clk);
                                mem_rd_rsp <= '{ack: 1'b1, data: mem_words[mem_rd_req.addr[9:2]]};
                                rd_count++;
                                do @(posedge clk); while (mem_rd_req.req);
                                mem_rd_rsp.ack <= 1'b0;
                        end
                end
        end

        initial begin
                int d;
                forever begin
                        @(posedge clk);
                        if (mem_wr_req.req === 1'b1 && !mem_wr_ack) begin
                                d = slow_writes ? pick_delay(5, 5) : pick_delay(0, 4);
                                repeat (d) @(posedge clk);
                                mem_words[mem_wr_req.addr[9:2]] = mem_wr_req.data;
                                wr_count++;
                                mem_wr_ack <= 1'b1;
                                do @(posedge clk); while (mem_wr_req.req);
                                mem_wr_ack <= 1'b0;
                        end
                end
        end

        always @(posedge clk) begin
                if (dut.done === 1'b1) begin
                        done_pulses++;
                end
        end

        //////////////////////////////////////////////////
        // copy helpers
        //////////////////////////////////////////////////
        task automatic start_copy(input gpu_pkg::addr_t src, input gpu_pkg::addr_t dst,
                                  input gpu_pkg::len_t len);
                exp_mem  = mem_words;
                rd_count = 0;
                wr_count = 0;
                // expected image: destination words take the source words
                for (int i = 0; i < len; i++) begin
                        exp_mem[dst[9:2] + i] = exp_mem[src[9:2] + i];
                end
                host_write(gpu_pkg::REG_SRC, src);
                host_write(gpu_pkg::REG_DST, dst);
                host_write(gpu_pkg::REG_LEN, len);
                host_write(gpu_pkg::REG_CTRL, 32'h1 << gpu_pkg::CTRL_GO_BIT);
        endtask

        task automatic wait_done();
                gpu_pkg::word_t st;
                do host_read(gpu_pkg::REG_STATUS, st); while (!st[gpu_pkg::STAT_DONE_BIT]);
                check_value("STATUS.busy", st[gpu_pkg::STAT_BUSY_BIT], 1'b0);
        endtask

        task automatic compare_memory();
                for (int i = 0; i < 256; i++) begin
                        check_value($sformatf("mem[%0d]", i), mem_words[i], exp_mem[i]);
                end
        endtask

        //////////////////////////////////////////////////
        // directed tests
        //////////////////////////////////////////////////
        task automatic reset_values_read_zero();
                gpu_pkg::word_t v;
                host_read(gpu_pkg::REG_SRC, v);
                check_value("SRC", v, 32'h0);
                host_read(gpu_pkg::REG_DST, v);
                check_value("DST", v, 32'h0);
                host_read(gpu_pkg::REG_LEN, v);
                check_value("LEN", v, 32'h0);
                host_read(gpu_pkg::REG_STATUS, v);
                check_value("STATUS", v, 32'h0);
        endtask

        task automatic register_readback();
                gpu_pkg::word_t v;
                host_write(gpu_pkg::REG_SRC, 32'h1234_5678);
                host_write(gpu_pkg::REG_DST, 32'h9abc_def0);
                host_write(gpu_pkg::REG_LEN, 32'h0000_0a5c);
                // go bit clear, so no copy starts
                host_write(gpu_pkg::REG_CTRL, 32'hffff_fffe);
                host_read(gpu_pkg::REG_SRC, v);
                check_value("SRC", v, 32'h1234_5678);
                host_read(gpu_pkg::REG_DST, v);
                check_value("DST", v, 32'h9abc_def0);
                host_read(gpu_pkg::REG_LEN, v);
                check_value("LEN", v, 32'h0000_0a5c);
                host_read(gpu_pkg::REG_CTRL, v);
                check_value("CTRL", v, 32'h0);
        endtask

        task automatic copy_twenty_words();
                start_copy(32'h000, 32'h100, 20);
                wait_done();
                compare_memory();
                check_value("read requests", rd_count, 20);
                check_value("write requests", wr_count, 20);
        endtask

        task automatic copy_under_backpressure();
                slow_writes = 1'b1;
                start_copy(32'h080, 32'h200, 40);
                wait_done();
                slow_writes = 1'b0;
                compare_memory();
                check_value("write requests", wr_count, 40);
        endtask

        task automatic copy_zero_length();
                // done is still set from the copy before, so count the pulse
                done_pulses = 0;
                start_copy(32'h040, 32'h0c0, 0);
                wait_done();
                compare_memory();
                check_value("read requests", rd_count, 0);
                check_value("write requests", wr_count, 0);
                check_value("done pulses", done_pulses, 1);
        endtask

        task automatic go_ignored_while_busy();
                gpu_pkg::word_t v;
                done_pulses = 0;
                start_copy(32'h300, 32'h380, BUSY_LEN);
                host_read(gpu_pkg::REG_STATUS, v);
                check_value("STATUS.busy", v[gpu_pkg::STAT_BUSY_BIT], 1'b1);
                host_write(gpu_pkg::REG_CTRL, 32'h1 << gpu_pkg::CTRL_GO_BIT);
                wait_done();
                // quiet period, a second copy would show up here
                repeat (60) @(posedge clk);
                compare_memory();
                check_value("write requests", wr_count, BUSY_LEN);
                check_value("done pulses", done_pulses, 1);
                host_read(gpu_pkg::REG_STATUS, v);
                check_value("STATUS", v, 32'h1 << gpu_pkg::STAT_DONE_BIT);
        endtask

        //////////////////////////////////////////////////
        // main sequence and watchdog
        //////////////////////////////////////////////////
        initial begin
                host_req   = '0;
                mem_rd_rsp = '0;
                mem_wr_ack = 1'b0;
                for (int i = 0; i < 256; i++) begin
                        mem_words[i] = $random(seed);
                end
                @(posedge arst_n);
                @(posedge clk);
                reset_values_read_zero();
                register_readback();
                copy_twenty_words();
                copy_under_backpressure();
                copy_zero_length();
                go_ignored_while_busy();
                $display("TESTS PASSED");
                $finish;
        end

        initial begin
                #(LIMIT_CYCLES * CLK_PERIOD);
                stop_with_failure("timeout: the tests did not finish in the allowed time");
        end

endmodule

// ==== sources.f ====
logic/gpu_pkg.sv
logic/gpu_regs.sv
logic/gpu_memcpy.sv
logic/gpu_dma_reader.sv
logic/gpu_fifo.sv
logic/gpu_dma_writer.sv
logic/gpu_top.sv
test/tb_clock.sv
test/tb_gpu_assert.sv
test/tb_gpu.sv
